// File: verilog/xgmii_pkg.sv
package xgmii_pkg;

    // byte lanes per xgmii word, lane 0 sits in the top byte
    localparam int LANES = 8;

    ////////////////////
    // control characters

    localparam logic [7:0] XGMII_IDLE  = 8'h07;  // /I/
    localparam logic [7:0] XGMII_START = 8'hFB;  // /S/
    localparam logic [7:0] XGMII_TERM  = 8'hFD;  // /T/

    ////////////////////
    // word level types

    typedef logic [8*LANES-1:0] xgmii_data_t;

    // bit 7 flags lane 0
    typedef logic [LANES-1:0] xgmii_ctrl_t;

    // byte enables, first byte in bit 7, packed from the top
    typedef logic [LANES-1:0] keep_t;

endpackage

// File: verilog/eth_pkg.sv
package eth_pkg;

    ////////////////////
    // frame format

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    localparam int HEADER_BYTES = 14;  // dst + src + type
    localparam int FCS_BYTES    = 4;

    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;
    typedef logic [31:0] fcs_t;
    typedef logic [15:0] len_t;

    localparam mac_addr_t BROADCAST_MAC     = 48'hFF_FF_FF_FF_FF_FF;
    localparam mac_addr_t LOCAL_MAC_DEFAULT = 48'h02_00_00_00_00_01;

    ////////////////////
    // crc-32, reflected form of 0x04C11DB7

    localparam logic [31:0] CRC32_POLY_REV = 32'hEDB8_8320;
    localparam logic [31:0] CRC32_INIT     = 32'hFFFF_FFFF;

    // one byte step, lsb of the byte goes in first
    function automatic logic [31:0] crc32_next_byte(input logic [31:0] crc,
                                                    input logic [7:0]  data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ CRC32_POLY_REV) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// File: verilog/frame_if.sv
interface frame_if
    import xgmii_pkg::*, eth_pkg::*;
();

    logic        valid;
    xgmii_data_t data;   // dst mac onward, fcs removed
    keep_t       keep;   // all ones except on the last beat
    logic        last;
    fcs_t        fcs;    // received fcs in wire order, with last

    modport source (
        output valid,
        output data,
        output keep,
        output last,
        output fcs
    );

    modport sink (
        input valid,
        input data,
        input keep,
        input last,
        input fcs
    );

endinterface

// File: verilog/xgmii_frame_decoder.sv
module xgmii_frame_decoder
    import xgmii_pkg::*, eth_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  xgmii_data_t i_xgmii_rxd,
    input  xgmii_ctrl_t i_xgmii_rxc,
    frame_if.source     o_frame
);

    xgmii_data_t r_rxd;         // input register
    xgmii_ctrl_t r_rxc;
    xgmii_data_t r_hold;        // word held back for fcs stripping
    logic        r_run;         // r_rxd is a frame word
    logic        r_hold_run;    // r_hold is a frame word
    logic        r_hold_term;   // r_hold carries /T/
    logic [2:0]  r_hold_tpos;

    logic         start_ok;
    logic         term_hit;
    logic [2:0]   term_pos;
    logic         next_ends;
    logic         hold_data;
    logic         tail_beat;
    logic [3:0]   beat_cnt;
    logic [3:0]   fcs_idx;
    logic [127:0] pair;

    ////////////////////
    // start and end detection on the registered word

    // /S/ in lane 0, six preamble bytes, then sfd
    assign start_ok = (r_rxc == 8'h80) &&
                      (r_rxd[63:56] == XGMII_START) &&
                      (r_rxd[55:8] == {6{PREAMBLE_BYTE}}) &&
                      (r_rxd[7:0] == SFD_BYTE);

    always_comb begin
        term_hit = 1'b0;
        term_pos = '0;
        // walk down so the lowest lane wins
        for (int i = LANES - 1; i >= 0; i--) begin
            if (r_rxc[LANES-1-i] && (r_rxd[63-8*i -: 8] == XGMII_TERM)) begin
                term_hit = 1'b1;
                term_pos = 3'(i);
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_rxc       <= '0;
            r_run       <= 1'b0;
            r_hold_run  <= 1'b0;
            r_hold_term <= 1'b0;
            r_hold_tpos <= '0;
        end else begin
            r_rxc       <= i_xgmii_rxc;
            r_hold_run  <= r_run;
            r_hold_term <= r_run && term_hit;
            r_hold_tpos <= term_pos;
            if (r_run && term_hit) begin
                r_run <= 1'b0;
            end else if (start_ok) begin
                r_run <= 1'b1;  // a bad preamble never opens a frame
            end
        end
    end

    always_ff @(posedge i_clk) begin
        r_rxd  <= i_xgmii_rxd;
        r_hold <= r_rxd;
    end

    ////////////////////
    // output beat from the held word

    // /T/ early in the next word, so fcs reaches back into r_hold
    assign next_ends = r_run && term_hit && (term_pos <= 3'd4);
    assign hold_data = r_hold_run && !r_hold_term;
    // /T/ late enough that data is left ahead of the fcs
    assign tail_beat = r_hold_run && r_hold_term && (r_hold_tpos > 3'd4);

    always_comb begin
        if (tail_beat) begin
            beat_cnt = {1'b0, r_hold_tpos} - 4'(FCS_BYTES);
            fcs_idx  = {1'b0, r_hold_tpos} - 4'(FCS_BYTES);
        end else begin
            beat_cnt = next_ends ? ({1'b0, term_pos} + 4'(FCS_BYTES)) : 4'd8;
            fcs_idx  = {1'b0, term_pos} + 4'(FCS_BYTES);
        end
    end

    assign pair = {r_hold, r_rxd};  // 16 bytes, fcs may straddle the boundary

    assign o_frame.valid = hold_data || tail_beat;
    assign o_frame.last  = (hold_data && next_ends) || tail_beat;
    assign o_frame.data  = r_hold;
    assign o_frame.keep  = ~(8'hFF >> beat_cnt);
    assign o_frame.fcs   = pair[8*(12 - fcs_idx) +: 32];

endmodule

// File: verilog/eth_header_filter.sv
module eth_header_filter
    import xgmii_pkg::*, eth_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  mac_addr_t   i_local_mac,
    input  logic        i_local_mac_valid,
    frame_if.sink       i_frame,
    output logic        o_accept,
    output xgmii_data_t o_rx_data,
    output keep_t       o_rx_keep,
    output logic        o_rx_last,
    output logic        o_rx_valid,
    output len_t        o_rx_len,
    output mac_addr_t   o_rx_src_mac,
    output eth_type_t   o_rx_type
);

    typedef enum logic [1:0] {
        BEAT_DST,      // dst mac + top of src
        BEAT_SRC,      // rest of src, type, first two payload bytes
        BEAT_PAYLOAD
    } beat_e;

    beat_e       r_beat;
    mac_addr_t   r_local_mac;
    logic        r_match;       // frame is for us
    logic        r_flush;       // leftover bytes still to send
    logic [3:0]  r_flush_cnt;
    logic [15:0] r_carry;       // last two bytes of the previous beat

    logic        dst_hit;
    logic [3:0]  in_cnt;
    logic [3:0]  out_cnt;
    logic        spill;

    assign dst_hit = (i_frame.data[63:16] == BROADCAST_MAC) ||
                     (i_frame.data[63:16] == r_local_mac);

    assign in_cnt  = 4'($countones(i_frame.keep));
    assign spill   = in_cnt > 4'd6;  // bytes 6..7 of a last beat need one more beat
    assign out_cnt = spill ? 4'd8 : (in_cnt + 4'd2);

    ////////////////////
    // control

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_local_mac <= LOCAL_MAC_DEFAULT;
            r_beat      <= BEAT_DST;
            r_match     <= 1'b0;
            r_flush     <= 1'b0;
            o_accept    <= 1'b0;
            o_rx_valid  <= 1'b0;
            o_rx_last   <= 1'b0;
        end else begin
            o_accept   <= 1'b0;
            o_rx_valid <= r_flush;
            o_rx_last  <= r_flush;
            r_flush    <= 1'b0;
            if (i_local_mac_valid) begin
                r_local_mac <= i_local_mac;
            end
            if (i_frame.valid) begin
                case (r_beat)
                    BEAT_DST: begin
                        r_match  <= dst_hit;
                        o_accept <= dst_hit;
                        r_beat   <= BEAT_SRC;
                    end
                    BEAT_SRC: begin
                        r_flush <= r_match && i_frame.last && spill;  // tiny payload
                        r_beat  <= BEAT_PAYLOAD;
                    end
                    default: begin
                        o_rx_valid <= r_match;
                        o_rx_last  <= r_match && i_frame.last && !spill;
                        r_flush    <= r_match && i_frame.last && spill;
                    end
                endcase
                if (i_frame.last) begin
                    r_beat <= BEAT_DST;
                end
            end
        end
    end

    ////////////////////
    // header fields and realigned payload

    always_ff @(posedge i_clk) begin
        if (r_flush) begin
            o_rx_data <= {r_carry, 48'd0};
            o_rx_keep <= ~(8'hFF >> r_flush_cnt);
            o_rx_len  <= o_rx_len + len_t'(r_flush_cnt);
        end
        if (i_frame.valid) begin
            r_carry     <= i_frame.data[15:0];
            r_flush_cnt <= in_cnt - 4'd6;
            case (r_beat)
                BEAT_DST: begin
                    o_rx_src_mac[47:32] <= i_frame.data[15:0];
                    o_rx_len            <= '0;  // new frame
                end
                BEAT_SRC: begin
                    o_rx_src_mac[31:0] <= i_frame.data[63:32];
                    o_rx_type          <= i_frame.data[31:16];
                end
                default: begin
                    o_rx_data <= {r_carry, i_frame.data[63:16]};  // shift up by six
                    o_rx_keep <= ~(8'hFF >> out_cnt);
                    o_rx_len  <= o_rx_len + len_t'(out_cnt);
                end
            endcase
        end
    end

endmodule

// File: verilog/crc32_frame_check.sv
module crc32_frame_check
    import xgmii_pkg::*, eth_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_accept,
    frame_if.sink i_frame,
    output logic  o_crc_valid,
    output logic  o_crc_error
);

    logic [31:0] r_crc;
    logic        r_first;     // next beat opens a frame
    logic        r_accepted;

    logic [31:0] crc_next;
    fcs_t        crc_rx;
    logic        taken;
    logic        frame_end;

    ////////////////////
    // byte chain over one beat

    always_comb begin
        crc_next = r_first ? CRC32_INIT : r_crc;
        for (int i = 0; i < LANES; i++) begin
            if (i_frame.keep[LANES-1-i]) begin
                crc_next = crc32_next_byte(crc_next, i_frame.data[63-8*i -: 8]);
            end
        end
    end

    // first fcs byte on the wire is the crc low byte
    assign crc_rx = {i_frame.fcs[7:0], i_frame.fcs[15:8],
                     i_frame.fcs[23:16], i_frame.fcs[31:24]};

    assign frame_end = i_frame.valid && i_frame.last;
    assign taken     = r_accepted || i_accept;  // accept may land on the last beat

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_first     <= 1'b1;
            r_accepted  <= 1'b0;
            o_crc_valid <= 1'b0;
            o_crc_error <= 1'b0;
        end else begin
            o_crc_valid <= frame_end && taken;
            o_crc_error <= frame_end && taken && (~crc_next != crc_rx);
            if (i_frame.valid) begin
                r_first <= i_frame.last;
            end
            if (frame_end) begin
                r_accepted <= 1'b0;
            end else if (i_accept) begin
                r_accepted <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_frame.valid) begin
            r_crc <= crc_next;
        end
    end

endmodule

// File: verilog/ten_gig_mac_rx.sv
module ten_gig_mac_rx
    import xgmii_pkg::*, eth_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  xgmii_data_t i_xgmii_rxd,
    input  xgmii_ctrl_t i_xgmii_rxc,
    input  mac_addr_t   i_local_mac,
    input  logic        i_local_mac_valid,
    output xgmii_data_t o_rx_data,
    output keep_t       o_rx_keep,
    output logic        o_rx_last,
    output logic        o_rx_valid,
    output len_t        o_rx_len,
    output mac_addr_t   o_rx_src_mac,
    output eth_type_t   o_rx_type,
    output logic        o_crc_valid,
    output logic        o_crc_error
);

    logic w_accept;  // filter kept the frame

    frame_if frame_bus ();

    xgmii_frame_decoder xgmii_frame_decoder_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_xgmii_rxd (i_xgmii_rxd),
        .i_xgmii_rxc (i_xgmii_rxc),
        .o_frame     (frame_bus.source)
    );

    eth_header_filter eth_header_filter_inst (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_local_mac       (i_local_mac),
        .i_local_mac_valid (i_local_mac_valid),
        .i_frame           (frame_bus.sink),
        .o_accept          (w_accept),
        .o_rx_data         (o_rx_data),
        .o_rx_keep         (o_rx_keep),
        .o_rx_last         (o_rx_last),
        .o_rx_valid        (o_rx_valid),
        .o_rx_len          (o_rx_len),
        .o_rx_src_mac      (o_rx_src_mac),
        .o_rx_type         (o_rx_type)
    );

    crc32_frame_check crc32_frame_check_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_accept    (w_accept),
        .i_frame     (frame_bus.sink),
        .o_crc_valid (o_crc_valid),
        .o_crc_error (o_crc_error)
    );

endmodule

// File: verif/mac_rx_properties.sv
module mac_rx_properties
    import xgmii_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_rx_valid,
    input  logic  i_rx_last,
    input  keep_t i_rx_keep,
    input  logic  i_crc_valid,
    input  logic  i_crc_error
);

    // packed from the top bit, no holes
    function automatic logic keep_packed(input keep_t k);
        return (k != '0) && (k == ~(8'hFF >> $countones(k)));
    endfunction

    ////////////////////
    // output stream rules

    keep_shape: assert property (@(posedge i_clk) disable iff (i_rst)
        i_rx_valid |-> keep_packed(i_rx_keep))
        else $error("rx keep empty or not contiguous");

    keep_full: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_rx_valid && !i_rx_last) |-> (i_rx_keep == 8'hFF))
        else $error("rx keep not full on a middle beat");

    crc_error_qualified: assert property (@(posedge i_clk) disable iff (i_rst)
        i_crc_error |-> i_crc_valid)
        else $error("crc error high without crc valid");

    last_qualified: assert property (@(posedge i_clk) disable iff (i_rst)
        i_rx_last |-> i_rx_valid)
        else $error("rx last high without rx valid");

endmodule

// File: verif/tb_checker.sv
module tb_checker
    import xgmii_pkg::*, eth_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  xgmii_data_t i_rx_data,
    input  keep_t       i_rx_keep,
    input  logic        i_rx_last,
    input  logic        i_rx_valid,
    input  len_t        i_rx_len,
    input  mac_addr_t   i_rx_src_mac,
    input  eth_type_t   i_rx_type,
    input  logic        i_crc_valid,
    input  logic        i_crc_error,
    output int          o_errors,
    output int          o_pending
);

    // one entry per expected payload beat
    xgmii_data_t exp_data [$];
    keep_t       exp_keep [$];
    logic        exp_last [$];
    len_t        exp_len  [$];
    mac_addr_t   exp_src  [$];
    eth_type_t   exp_type [$];
    logic        exp_err  [$];   // one per accepted frame

    task automatic expect_beat(input xgmii_data_t d, input keep_t k, input logic l,
                               input len_t n, input mac_addr_t s, input eth_type_t t);
        exp_data.push_back(d);
        exp_keep.push_back(k);
        exp_last.push_back(l);
        exp_len.push_back(n);
        exp_src.push_back(s);
        exp_type.push_back(t);
    endtask

    task automatic expect_crc(input logic e);
        exp_err.push_back(e);
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("[FAIL] %0t %s is %h, expected %h", $time, what, got, want);
        o_errors++;
    endtask

    function automatic logic [63:0] byte_mask(input keep_t k);
        logic [63:0] m;
        for (int i = 0; i < LANES; i++) begin
            m[8*i +: 8] = {8{k[i]}};
        end
        return m;
    endfunction

    task automatic check_beat();
        logic [63:0] got;
        got = i_rx_data & byte_mask(exp_keep[0]);  // bytes past keep are don't care
        if (got !== exp_data[0]) begin
            report_mismatch("rx data", got, exp_data[0]);
        end
        if (i_rx_keep !== exp_keep[0]) begin
            report_mismatch("rx keep", 64'(i_rx_keep), 64'(exp_keep[0]));
        end
        if (i_rx_last !== exp_last[0]) begin
            report_mismatch("rx last", 64'(i_rx_last), 64'(exp_last[0]));
        end
        if (exp_last[0]) begin
            if (i_rx_len !== exp_len[0]) begin
                report_mismatch("rx len", 64'(i_rx_len), 64'(exp_len[0]));
            end
            if (i_rx_src_mac !== exp_src[0]) begin
                report_mismatch("rx src mac", 64'(i_rx_src_mac), 64'(exp_src[0]));
            end
            if (i_rx_type !== exp_type[0]) begin
                report_mismatch("rx type", 64'(i_rx_type), 64'(exp_type[0]));
            end
        end
        void'(exp_data.pop_front());
        void'(exp_keep.pop_front());
        void'(exp_last.pop_front());
        void'(exp_len.pop_front());
        void'(exp_src.pop_front());
        void'(exp_type.pop_front());
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge i_clk) begin
        if (!i_rst && i_rx_valid) begin
            if (exp_data.size() == 0) begin
                $display("payload beat at time %0t arrived with nothing expected", $time);
                o_errors++;
            end else begin
                check_beat();
            end
        end
        if (!i_rst && i_crc_valid) begin
            if (exp_err.size() == 0) begin
                $display("crc result at time %0t arrived for no accepted frame", $time);
                o_errors++;
            end else begin
                if (i_crc_error !== exp_err[0]) begin
                    report_mismatch("crc error", 64'(i_crc_error), 64'(exp_err[0]));
                end
                void'(exp_err.pop_front());
            end
        end
        o_pending = exp_data.size() + exp_err.size();
    end

endmodule

// File: verif/tb_top.sv
module tb_top
    import xgmii_pkg::*, eth_pkg::*;
();

    logic        i_clk;
    logic        i_rst;
    xgmii_data_t i_xgmii_rxd;
    xgmii_ctrl_t i_xgmii_rxc;
    mac_addr_t   i_local_mac;
    logic        i_local_mac_valid;
    xgmii_data_t o_rx_data;
    keep_t       o_rx_keep;
    logic        o_rx_last;
    logic        o_rx_valid;
    len_t        o_rx_len;
    mac_addr_t   o_rx_src_mac;
    eth_type_t   o_rx_type;
    logic        o_crc_valid;
    logic        o_crc_error;

    int          errors;
    int          pending;
    int          timeouts;
    integer      seed;
    mac_addr_t   dut_mac;         // address the DUT should match right now
    logic [7:0]  fbuf [0:127];    // dst mac through fcs of the frame being built

    ten_gig_mac_rx ten_gig_mac_rx_inst (.*);

    tb_checker scoreboard (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_rx_data    (o_rx_data),
        .i_rx_keep    (o_rx_keep),
        .i_rx_last    (o_rx_last),
        .i_rx_valid   (o_rx_valid),
        .i_rx_len     (o_rx_len),
        .i_rx_src_mac (o_rx_src_mac),
        .i_rx_type    (o_rx_type),
        .i_crc_valid  (o_crc_valid),
        .i_crc_error  (o_crc_error),
        .o_errors     (errors),
        .o_pending    (pending)
    );

    bind ten_gig_mac_rx mac_rx_properties rx_props (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_rx_valid  (o_rx_valid),
        .i_rx_last   (o_rx_last),
        .i_rx_keep   (o_rx_keep),
        .i_crc_valid (o_crc_valid),
        .i_crc_error (o_crc_error)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    ////////////////////
    // reference model

    // fcs value of the first n bytes of fbuf
    function automatic fcs_t frame_fcs(input int n);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++) begin
            c = crc32_next_byte(c, fbuf[i]);
        end
        return ~c;
    endfunction

    // payload bytes b onward packed from the top byte, zero past the payload end
    function automatic xgmii_data_t payload_word(input int b, input int n);
        xgmii_data_t d;
        d = '0;
        for (int k = 0; k < LANES; k++) begin
            if (b + k < n) begin
                d[63-8*k -: 8] = fbuf[HEADER_BYTES + b + k];
            end
        end
        return d;
    endfunction

    function automatic int rand_len();
        return 1 + int'($unsigned($random(seed)) % 64);
    endfunction

    ////////////////////
    // stimulus

    task automatic send_idle(input int cycles);
        repeat (cycles) begin
            @(posedge i_clk);
            i_xgmii_rxd <= {LANES{XGMII_IDLE}};
            i_xgmii_rxc <= '1;
        end
    endtask

    task automatic drive_frame(input int m, input logic bad_sfd);
        xgmii_data_t d;
        xgmii_ctrl_t c;
        int          idx;
        @(posedge i_clk);
        i_xgmii_rxd <= {XGMII_START, {6{PREAMBLE_BYTE}}, bad_sfd ? 8'hD4 : SFD_BYTE};
        i_xgmii_rxc <= 8'h80;
        // the /T/ word always goes out even with /T/ in lane 0
        for (int w = 0; w <= m / 8; w++) begin
            for (int lane = 0; lane < LANES; lane++) begin
                idx               = 8 * w + lane;
                c[LANES-1-lane]   = idx >= m;
                d[63-8*lane -: 8] = idx < m ? fbuf[idx] : (idx == m ? XGMII_TERM : XGMII_IDLE);
            end
            @(posedge i_clk);
            i_xgmii_rxd <= d;
            i_xgmii_rxc <= c;
        end
        send_idle(4);
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (pending != 0 && t < 100) begin
            @(posedge i_clk);
            t++;
        end
        if (pending != 0) begin
            $display("timed out at %0t waiting for %0d expected outputs", $time, pending);
            timeouts++;
        end
    endtask

    // build and predict the frame before driving it and letting the outputs drain
    task automatic send_frame(input mac_addr_t dst, input int n, input logic bad_fcs,
                              input logic bad_sfd);
        mac_addr_t   src;
        eth_type_t   etype;
        fcs_t        fcs;
        int          cnt;
        src   = {16'h0200, 32'($random(seed))};
        etype = 16'($random(seed));
        for (int i = 0; i < 6; i++) begin
            fbuf[i]     = dst[47-8*i -: 8];
            fbuf[6 + i] = src[47-8*i -: 8];
        end
        fbuf[12] = etype[15:8];
        fbuf[13] = etype[7:0];
        for (int i = 0; i < n; i++) begin
            fbuf[HEADER_BYTES + i] = 8'($random(seed));
        end
        fcs    = frame_fcs(HEADER_BYTES + n);
        fcs[9] = fcs[9] ^ bad_fcs;
        for (int i = 0; i < FCS_BYTES; i++) begin
            fbuf[HEADER_BYTES + n + i] = fcs[8*i +: 8];  // low byte first on the wire
        end
        if (!bad_sfd && (dst == BROADCAST_MAC || dst == dut_mac)) begin
            for (int b = 0; b < n; b += 8) begin
                cnt = (n - b > 8) ? 8 : n - b;
                scoreboard.expect_beat(payload_word(b, n), ~(8'hFF >> cnt), b + 8 >= n,
                                       len_t'(n), src, etype);
            end
            scoreboard.expect_crc(bad_fcs);
        end
        drive_frame(HEADER_BYTES + n + FCS_BYTES, bad_sfd);
        wait_drained();
    endtask

    initial begin
        seed              = 32'h04eb_3102;
        timeouts          = 0;
        dut_mac           = LOCAL_MAC_DEFAULT;
        i_rst             = 1'b1;
        i_xgmii_rxd       = {LANES{XGMII_IDLE}};
        i_xgmii_rxc       = '1;
        i_local_mac       = '0;
        i_local_mac_valid = 1'b0;
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;
        send_idle(2);
        // every tail position first and random lengths after
        for (int n = 1; n <= 16; n++) begin
            send_frame(dut_mac, n, 1'b0, 1'b0);
        end
        repeat (12) send_frame(dut_mac, rand_len(), 1'b0, 1'b0);
        repeat (3) send_frame(BROADCAST_MAC, rand_len(), 1'b0, 1'b0);
        send_frame(48'h02_00_00_00_00_99, rand_len(), 1'b0, 1'b0);  // not for us
        send_frame(48'hFF_FF_FF_FF_FF_FE, rand_len(), 1'b0, 1'b0);
        repeat (3) send_frame(dut_mac, rand_len(), 1'b1, 1'b0);
        @(posedge i_clk);
        i_local_mac       <= 48'h02_00_00_00_00_2A;
        i_local_mac_valid <= 1'b1;
        @(posedge i_clk);
        i_local_mac_valid <= 1'b0;
        dut_mac = 48'h02_00_00_00_00_2A;
        send_frame(LOCAL_MAC_DEFAULT, rand_len(), 1'b0, 1'b0);  // old address now dropped
        send_frame(dut_mac, rand_len(), 1'b0, 1'b0);
        send_frame(dut_mac, rand_len(), 1'b0, 1'b1);  // wrong sfd
        send_frame(dut_mac, rand_len(), 1'b0, 1'b0);
        send_idle(8);
        wait_drained();
        $display("done: %0d mismatches, %0d timeouts, %0d expected outputs never seen",
                 errors, timeouts, pending);
        if (errors == 0 && timeouts == 0 && pending == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: build.f
verilog/xgmii_pkg.sv
verilog/eth_pkg.sv
verilog/frame_if.sv
verilog/xgmii_frame_decoder.sv
verilog/eth_header_filter.sv
verilog/crc32_frame_check.sv
verilog/ten_gig_mac_rx.sv
verif/mac_rx_properties.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_top with Verilator and run the simulation"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_top -Mdir obj_dir
	./obj_dir/Vtb_top > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
